// File: cpuPkg.sv
package cpuPkg;

    // one data word on every bus and register
    typedef logic [7:0] byteT;

    // ALU function select
    typedef enum logic [2:0] {
        opNone,
        opSum,
        opAnd,
        opEor,
        opOr,
        opShr
    } aluOpT;

    // source that drives the special bus in a cycle
    typedef enum logic [2:0] {
        srcData,
        srcAcc,
        srcX,
        srcY,
        srcS,
        srcAdd,
        srcZero
    } sbSrcT;

    // adder hold contents with overflow, carry and half carry
    typedef struct packed {
        byteT value;
        logic avr;
        logic acr;
        logic hc;
    } aluResT;

    // status byte layout NV-BDIZC
    localparam int statusBitC = 0;
    localparam int statusBitZ = 1;
    localparam int statusBitI = 2;
    localparam int statusBitD = 3;
    localparam int statusBitB = 4;
    localparam int statusBitV = 6;
    localparam int statusBitN = 7;

    // bit 5 set and every flag clear
    localparam byteT statusReset = 8'h20;

    // BCD correction constants
    localparam byteT bcdLowFix = 8'h06;
    localparam byteT bcdHighFix = 8'h60;
    localparam byteT bcdMax = 8'h99;
    localparam logic [3:0] bcdDigitMax = 4'd9;

endpackage

// File: aluCtrlIf.sv
interface aluCtrlIf;
    import cpuPkg::*;

    aluOpT op;
    logic carryIn;
    logic invertB;
    // decimal add / subtract adjust requests
    logic daa;
    logic dsa;

    modport ctrl (
        output op, carryIn, invertB, daa, dsa
    );

    modport alu (
        input op, carryIn, invertB, daa, dsa
    );

endinterface

// File: dataLatch.sv
module dataLatch (
    input  logic          phi2,
    input  logic          rst,
    input  cpuPkg::byteT  dataIn,
    input  cpuPkg::sbSrcT sbSel,
    input  cpuPkg::byteT  acc,
    input  cpuPkg::byteT  xReg,
    input  cpuPkg::byteT  yReg,
    input  cpuPkg::byteT  sReg,
    input  cpuPkg::byteT  addHold,
    output cpuPkg::byteT  latched,
    output cpuPkg::byteT  sb
);
    import cpuPkg::*;

    byteT dataQ;

    // external data is captured every cycle
    always_ff @(posedge phi2 or posedge rst) begin
        if (rst) begin
            dataQ <= '0;
        end else begin
            dataQ <= dataIn;
        end
    end

    assign latched = dataQ;

    // one source drives SB per cycle
    always_comb begin
        case (sbSel)
            srcData: sb = dataQ;
            srcAcc:  sb = acc;
            srcX:    sb = xReg;
            srcY:    sb = yReg;
            srcS:    sb = sReg;
            srcAdd:  sb = addHold;
            default: sb = '0;
        endcase
    end

endmodule

// File: aluCore.sv
module aluCore (
    input  logic           phi2,
    input  logic           rst,
    aluCtrlIf.alu          ctrl,
    input  cpuPkg::byteT   sb,
    input  cpuPkg::byteT   data,
    output cpuPkg::aluResT hold
);
    import cpuPkg::*;

    byteT opA;
    byteT opB;
    logic [8:0] sum;
    logic [4:0] halfSum;
    aluResT res;
    aluResT holdQ;

    assign opA = sb;
    // inverted B turns the adder into a subtractor
    assign opB = ctrl.invertB ? ~data : data;

    assign sum = {1'b0, opA} + {1'b0, opB} + {8'd0, ctrl.carryIn};
    // half carry ignores carry in
    assign halfSum = {1'b0, opA[3:0]} + {1'b0, opB[3:0]};

    always_comb begin
        res = '0;
        case (ctrl.op)
            opSum: begin
                res.value = sum[7:0];
                res.acr = sum[8];
                res.avr = (opA[7] == opB[7]) && (sum[7] != opA[7]);
                res.hc = halfSum[4];
            end
            opAnd: res.value = opA & opB;
            opEor: res.value = opA ^ opB;
            opOr:  res.value = opA | opB;
            opShr: begin
                // carry in rotates into the top bit
                res.value = {ctrl.carryIn, opB[7:1]};
                res.acr = opB[0];
            end
            default: res = '0;
        endcase
    end

    // adder hold register loaded every cycle
    always_ff @(posedge phi2 or posedge rst) begin
        if (rst) begin
            holdQ <= '0;
        end else begin
            holdQ <= res;
        end
    end

    assign hold = holdQ;

    // the controller must never issue an undefined function code
    opLegal: assert property (@(posedge phi2) disable iff (rst)
        ctrl.op inside {opNone, opSum, opAnd, opEor, opOr, opShr});

endmodule

// File: decimalAdjust.sv
module decimalAdjust (
    input  logic         phi2,
    input  logic         rst,
    aluCtrlIf.alu        ctrl,
    input  cpuPkg::byteT sb,
    input  logic         acr,
    input  logic         hc,
    output cpuPkg::byteT adjusted
);
    import cpuPkg::*;

    logic daaQ;
    logic dsaQ;

    // decimal mode follows the ALU operation by one cycle
    always_ff @(posedge phi2 or posedge rst) begin
        if (rst) begin
            daaQ <= 1'b0;
            dsaQ <= 1'b0;
        end else begin
            daaQ <= ctrl.daa;
            dsaQ <= ctrl.dsa;
        end
    end

    always_comb begin
        adjusted = sb;
        if (daaQ) begin
            if ((sb[3:0] > bcdDigitMax) || hc) begin
                adjusted = adjusted + bcdLowFix;
            end
            // high digit check uses the uncorrected value
            if (acr || (sb > bcdMax)) begin
                adjusted = adjusted + bcdHighFix;
            end
        end else if (dsaQ) begin
            if (!hc) begin
                adjusted = adjusted - bcdLowFix;
            end
            if (!acr) begin
                adjusted = adjusted - bcdHighFix;
            end
        end
    end

    decModeExclusive: assert property (@(posedge phi2) disable iff (rst)
        !(ctrl.daa && ctrl.dsa));

endmodule

// File: registerFile.sv
module registerFile (
    input  logic         phi2,
    input  logic         rst,
    input  cpuPkg::byteT sb,
    input  cpuPkg::byteT accIn,
    input  logic         loadAcc,
    input  logic         loadX,
    input  logic         loadY,
    input  logic         loadS,
    output cpuPkg::byteT acc,
    output cpuPkg::byteT xReg,
    output cpuPkg::byteT yReg,
    output cpuPkg::byteT sReg
);
    import cpuPkg::*;

    byteT accQ;
    byteT xQ;
    byteT yQ;
    byteT sQ;

    always_ff @(posedge phi2 or posedge rst) begin
        if (rst) begin
            accQ <= '0;
            xQ <= '0;
            yQ <= '0;
            sQ <= '0;
        end else begin
            // accumulator is fed through the decimal adjuster
            if (loadAcc) begin
                accQ <= accIn;
            end
            if (loadX) begin
                xQ <= sb;
            end
            if (loadY) begin
                yQ <= sb;
            end
            if (loadS) begin
                sQ <= sb;
            end
        end
    end

    assign acc = accQ;
    assign xReg = xQ;
    assign yReg = yQ;
    assign sReg = sQ;

endmodule

// File: statusReg.sv
module statusReg (
    input  logic           phi2,
    input  logic           rst,
    input  cpuPkg::aluResT hold,
    input  cpuPkg::byteT   sb,
    input  logic           flagsAluNzcv,
    input  logic           flagsAluNz,
    input  logic           flagsBusNz,
    input  logic           setC,
    input  logic           clrC,
    input  logic           setI,
    input  logic           clrI,
    input  logic           clrV,
    input  logic           setD,
    input  logic           clrD,
    output cpuPkg::byteT   status
);
    import cpuPkg::*;

    byteT statusQ;
    byteT statusNext;

    always_comb begin
        statusNext = statusQ;
        if (flagsAluNzcv) begin
            statusNext[statusBitN] = hold.value[7];
            statusNext[statusBitZ] = (hold.value == '0);
            statusNext[statusBitC] = hold.acr;
            statusNext[statusBitV] = hold.avr;
        end else if (flagsAluNz) begin
            statusNext[statusBitN] = hold.value[7];
            statusNext[statusBitZ] = (hold.value == '0);
        end else if (flagsBusNz) begin
            statusNext[statusBitN] = sb[7];
            statusNext[statusBitZ] = (sb == '0);
        end else begin
            // set has priority over clear
            if (setC || clrC) begin
                statusNext[statusBitC] = setC;
            end
            if (setI || clrI) begin
                statusNext[statusBitI] = setI;
            end
            if (setD || clrD) begin
                statusNext[statusBitD] = setD;
            end
            if (clrV) begin
                statusNext[statusBitV] = 1'b0;
            end
        end
        // B and the unused bit are fixed
        statusNext[statusBitB] = statusReset[statusBitB];
        statusNext[statusBitB + 1] = statusReset[statusBitB + 1];
    end

    always_ff @(posedge phi2 or posedge rst) begin
        if (rst) begin
            statusQ <= statusReset;
        end else begin
            statusQ <= statusNext;
        end
    end

    assign status = statusQ;

    strobePairs: assert property (@(posedge phi2) disable iff (rst)
        !(setC && clrC) && !(setI && clrI) && !(setD && clrD));

endmodule

// File: cpuDatapath.sv
module cpuDatapath (
    input  logic           phi2,
    input  logic           rst,
    input  cpuPkg::byteT   dataIn,
    input  cpuPkg::sbSrcT  sbSel,
    input  cpuPkg::aluOpT  aluOp,
    input  logic           carryIn,
    input  logic           invertB,
    input  logic           daa,
    input  logic           dsa,
    input  logic           loadAcc,
    input  logic           loadX,
    input  logic           loadY,
    input  logic           loadS,
    input  logic           flagsAluNzcv,
    input  logic           flagsAluNz,
    input  logic           flagsBusNz,
    input  logic           setC,
    input  logic           clrC,
    input  logic           setI,
    input  logic           clrI,
    input  logic           clrV,
    input  logic           setD,
    input  logic           clrD,
    output cpuPkg::byteT   acc,
    output cpuPkg::byteT   xReg,
    output cpuPkg::byteT   yReg,
    output cpuPkg::byteT   sReg,
    output cpuPkg::byteT   status,
    output cpuPkg::aluResT addHold
);
    import cpuPkg::*;

    byteT latched;
    byteT sb;
    byteT adjusted;

    aluCtrlIf aluCtrl ();

    // ALU control comes straight from the pins
    assign aluCtrl.op = aluOp;
    assign aluCtrl.carryIn = carryIn;
    assign aluCtrl.invertB = invertB;
    assign aluCtrl.daa = daa;
    assign aluCtrl.dsa = dsa;

    dataLatch uDataLatch (
        .phi2(phi2), .rst(rst), .dataIn(dataIn), .sbSel(sbSel),
        .acc(acc), .xReg(xReg), .yReg(yReg), .sReg(sReg),
        .addHold(addHold.value), .latched(latched), .sb(sb)
    );

    aluCore uAluCore (
        .phi2(phi2), .rst(rst), .ctrl(aluCtrl.alu),
        .sb(sb), .data(latched), .hold(addHold)
    );

    decimalAdjust uDecimalAdjust (
        .phi2(phi2), .rst(rst), .ctrl(aluCtrl.alu), .sb(sb),
        .acr(addHold.acr), .hc(addHold.hc), .adjusted(adjusted)
    );

    registerFile uRegisterFile (
        .phi2(phi2), .rst(rst), .sb(sb), .accIn(adjusted),
        .loadAcc(loadAcc), .loadX(loadX), .loadY(loadY), .loadS(loadS),
        .acc(acc), .xReg(xReg), .yReg(yReg), .sReg(sReg)
    );

    statusReg uStatusReg (
        .phi2(phi2), .rst(rst), .hold(addHold), .sb(sb),
        .flagsAluNzcv(flagsAluNzcv), .flagsAluNz(flagsAluNz), .flagsBusNz(flagsBusNz),
        .setC(setC), .clrC(clrC), .setI(setI), .clrI(clrI), .clrV(clrV),
        .setD(setD), .clrD(clrD), .status(status)
    );

endmodule

// File: tbCpuDatapath.sv
module tbCpuDatapath;
    import cpuPkg::*;

    // expected accumulator and status after one operation
    typedef struct packed {
        byteT acc;
        byteT status;
    } expT;

    // one pending compare of a register and the status byte
    typedef struct packed {
        logic [1:0] which;
        byteT value;
        byteT status;
    } checkT;

    localparam int rounds = 8;
    localparam int testCount = rounds * 16 + 10;

    logic phi2;
    logic rst;
    byteT dataIn;
    sbSrcT sbSel;
    aluOpT aluOp;
    logic carryIn;
    logic invertB;
    logic daa;
    logic dsa;
    logic loadAcc;
    logic loadX;
    logic loadY;
    logic loadS;
    logic flagsAluNzcv;
    logic flagsAluNz;
    logic flagsBusNz;
    logic setC;
    logic clrC;
    logic setI;
    logic clrI;
    logic clrV;
    logic setD;
    logic clrD;
    byteT acc;
    byteT xReg;
    byteT yReg;
    byteT sReg;
    byteT status;
    aluResT addHold;

    integer seed;
    int errors;
    byteT modelAcc;
    byteT modelStatus;
    checkT pending[$];

    cpuDatapath uut (
        .phi2(phi2), .rst(rst), .dataIn(dataIn), .sbSel(sbSel), .aluOp(aluOp),
        .carryIn(carryIn), .invertB(invertB), .daa(daa), .dsa(dsa),
        .loadAcc(loadAcc), .loadX(loadX), .loadY(loadY), .loadS(loadS),
        .flagsAluNzcv(flagsAluNzcv), .flagsAluNz(flagsAluNz), .flagsBusNz(flagsBusNz),
        .setC(setC), .clrC(clrC), .setI(setI), .clrI(clrI), .clrV(clrV),
        .setD(setD), .clrD(clrD), .acc(acc), .xReg(xReg), .yReg(yReg),
        .sReg(sReg), .status(status), .addHold(addHold)
    );

    initial begin
        phi2 = 1'b0;
        forever #50 phi2 = ~phi2;
    end

    function automatic expT refModel(byteT a, byteT operand, aluOpT op, logic cin,
                                     logic inv, logic dec, logic decSub, int flagMode,
                                     byteT st);
        byteT b;
        byteT value;
        byteT adj;
        int total;
        int lowSum;
        logic carry;
        logic ovf;
        logic half;
        expT e;
        b = inv ? ~operand : operand;
        value = 8'h00;
        carry = 1'b0;
        ovf = 1'b0;
        half = 1'b0;
        case (op)
            opSum: begin
                total = a + b + cin;
                value = byteT'(total);
                carry = total > 255;
                // half carry is taken from the nibbles alone
                lowSum = a[3:0] + b[3:0];
                half = lowSum > 15;
                ovf = (a[7] == b[7]) && (value[7] != a[7]);
            end
            opAnd: value = a & b;
            opEor: value = a ^ b;
            opOr:  value = a | b;
            opShr: begin
                value = {cin, b[7:1]};
                carry = b[0];
            end
            default: value = 8'h00;
        endcase
        adj = value;
        if (dec) begin
            if ((value[3:0] > 9) || half) adj = adj + 8'h06;
            if (carry || (value > 8'h99)) adj = adj + 8'h60;
        end else if (decSub) begin
            if (!half) adj = adj - 8'h06;
            if (!carry) adj = adj - 8'h60;
        end
        // flags come from the binary result in the hold register
        if (flagMode != 0) begin
            st[statusBitN] = value[7];
            st[statusBitZ] = (value == 8'h00);
        end
        if (flagMode == 1) begin
            st[statusBitC] = carry;
            st[statusBitV] = ovf;
        end
        e.acc = adj;
        e.status = st;
        return e;
    endfunction

    function automatic byteT randomBcd();
        integer hi;
        integer lo;
        hi = $unsigned($random(seed)) % 10;
        lo = $unsigned($random(seed)) % 10;
        return {hi[3:0], lo[3:0]};
    endfunction

    task automatic checkByte(string name, byteT expected, byteT actual);
        if (expected !== actual) begin
            $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic checkStatus(byteT expected, byteT actual);
        if (expected !== actual) begin
            $display("MISMATCH time=%0t status expected=%b actual=%b", $time, expected, actual);
            errors++;
        end
    endtask

    task automatic checkHold(aluResT expected, aluResT actual);
        if (expected !== actual) begin
            $display("MISMATCH time=%0t addHold expected=%h actual=%h", $time, expected, actual);
            errors++;
        end
    endtask

    task automatic idleControls();
        sbSel <= srcZero;
        aluOp <= opNone;
        carryIn <= 1'b0;
        invertB <= 1'b0;
        daa <= 1'b0;
        dsa <= 1'b0;
        loadAcc <= 1'b0;
        loadX <= 1'b0;
        loadY <= 1'b0;
        loadS <= 1'b0;
        flagsAluNzcv <= 1'b0;
        flagsAluNz <= 1'b0;
        flagsBusNz <= 1'b0;
        setC <= 1'b0;
        clrC <= 1'b0;
        setI <= 1'b0;
        clrI <= 1'b0;
        clrV <= 1'b0;
        setD <= 1'b0;
        clrD <= 1'b0;
    endtask

    // operand in cycle k, ALU in k+1, write back in k+2
    task automatic runAluOp(byteT operand, aluOpT op, logic cin, logic inv,
                            logic dec, logic decSub, int flagMode);
        expT e;
        e = refModel(modelAcc, operand, op, cin, inv, dec, decSub, flagMode, modelStatus);
        idleControls();
        dataIn <= operand;
        @(posedge phi2);
        idleControls();
        sbSel <= srcAcc;
        aluOp <= op;
        carryIn <= cin;
        invertB <= inv;
        daa <= dec;
        dsa <= decSub;
        @(posedge phi2);
        idleControls();
        sbSel <= srcAdd;
        loadAcc <= 1'b1;
        flagsAluNzcv <= (flagMode == 1);
        flagsAluNz <= (flagMode == 2);
        @(posedge phi2);
        modelAcc = e.acc;
        modelStatus = e.status;
        pending.push_back({2'd0, modelAcc, modelStatus});
    endtask

    task automatic loadAccumulator(byteT value);
        idleControls();
        dataIn <= value;
        @(posedge phi2);
        idleControls();
        sbSel <= srcData;
        loadAcc <= 1'b1;
        flagsBusNz <= 1'b1;
        @(posedge phi2);
        modelAcc = value;
        modelStatus[statusBitN] = value[7];
        modelStatus[statusBitZ] = (value == 8'h00);
        pending.push_back({2'd0, modelAcc, modelStatus});
    endtask

    // which selects X, Y or S as 1, 2, 3
    task automatic transferAcc(logic [1:0] which);
        idleControls();
        sbSel <= srcAcc;
        flagsBusNz <= 1'b1;
        loadX <= (which == 2'd1);
        loadY <= (which == 2'd2);
        loadS <= (which == 2'd3);
        @(posedge phi2);
        modelStatus[statusBitN] = modelAcc[7];
        modelStatus[statusBitZ] = (modelAcc == 8'h00);
        pending.push_back({which, modelAcc, modelStatus});
    endtask

    task automatic strobeFlag(int bitPos, logic value);
        idleControls();
        case (bitPos)
            statusBitC: begin
                setC <= value;
                clrC <= !value;
            end
            statusBitI: begin
                setI <= value;
                clrI <= !value;
            end
            statusBitD: begin
                setD <= value;
                clrD <= !value;
            end
            default: clrV <= 1'b1;
        endcase
        @(posedge phi2);
        modelStatus[bitPos] = value;
        pending.push_back({2'd0, modelAcc, modelStatus});
    endtask

    // results are compared half a cycle after the edge that wrote them
    initial begin : compareProc
        checkT item;
        forever begin
            @(negedge phi2);
            while (pending.size() > 0) begin
                item = pending.pop_front();
                case (item.which)
                    2'd0: checkByte("acc", item.value, acc);
                    2'd1: checkByte("xReg", item.value, xReg);
                    2'd2: checkByte("yReg", item.value, yReg);
                    default: checkByte("sReg", item.value, sReg);
                endcase
                checkStatus(item.status, status);
            end
        end
    end

    initial begin : watchdog
        #((testCount * 3 + 40) * 100);
        $display("timeout: the datapath sequence did not complete in time, %0d errors", errors);
        $display("tests failed");
        $finish;
    end

    initial begin : stimulus
        integer r;
        logic cin;
        seed = 32'hf798;
        errors = 0;
        modelAcc = 8'h00;
        modelStatus = statusReset;
        rst = 1'b1;
        dataIn = 8'h00;
        idleControls();
        repeat (16) @(posedge phi2);
        rst <= 1'b0;
        @(negedge phi2);
        checkByte("acc", 8'h00, acc);
        checkByte("xReg", 8'h00, xReg);
        checkByte("yReg", 8'h00, yReg);
        checkByte("sReg", 8'h00, sReg);
        checkHold('0, addHold);
        checkStatus(statusReset, status);
        @(posedge phi2);
        for (int i = 0; i < rounds; i++) begin
            // 80h plus 80h leaves C and V high ahead of the logic ops
            loadAccumulator(8'h80);
            runAluOp(8'h80, opSum, 1'b0, 1'b0, 1'b0, 1'b0, 1);
            loadAccumulator(byteT'($random(seed)));
            runAluOp(byteT'($random(seed)), opAnd, 1'b0, 1'b0, 1'b0, 1'b0, 2);
            runAluOp(byteT'($random(seed)), opEor, 1'b0, 1'b0, 1'b0, 1'b0, 2);
            runAluOp(byteT'($random(seed)), opOr, 1'b0, 1'b0, 1'b0, 1'b0, 2);
            r = $random(seed);
            cin = r[0];
            runAluOp(byteT'($random(seed)), opSum, cin, 1'b0, 1'b0, 1'b0, 1);
            r = $random(seed);
            cin = r[0];
            // subtract with carry in as the inverted borrow
            runAluOp(byteT'($random(seed)), opSum, cin, 1'b1, 1'b0, 1'b0, 1);
            loadAccumulator(randomBcd());
            runAluOp(randomBcd(), opSum, 1'b0, 1'b0, 1'b1, 1'b0, 1);
            loadAccumulator(randomBcd());
            runAluOp(randomBcd(), opSum, 1'b1, 1'b1, 1'b0, 1'b1, 1);
            r = $random(seed);
            cin = r[0];
            runAluOp(byteT'($random(seed)), opShr, cin, 1'b0, 1'b0, 1'b0, 1);
            transferAcc(2'd1);
            transferAcc(2'd2);
            transferAcc(2'd3);
        end
        // raise C and V so that every strobe below changes its bit
        loadAccumulator(8'h80);
        runAluOp(8'h80, opSum, 1'b0, 1'b0, 1'b0, 1'b0, 1);
        strobeFlag(statusBitC, 1'b0);
        strobeFlag(statusBitC, 1'b1);
        strobeFlag(statusBitI, 1'b1);
        strobeFlag(statusBitI, 1'b0);
        strobeFlag(statusBitD, 1'b1);
        strobeFlag(statusBitD, 1'b0);
        strobeFlag(statusBitV, 1'b0);
        idleControls();
        repeat (2) @(negedge phi2);
        if (pending.size() != 0) begin
            $display("compare queue still holds %0d entries at the end", pending.size());
            errors++;
        end
        $display("run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
cpuPkg.sv
aluCtrlIf.sv
dataLatch.sv
aluCore.sv
decimalAdjust.sv
registerFile.sv
statusReg.sv
cpuDatapath.sv
tbCpuDatapath.sv

// File: Bender.yml
package:
  name: cpu_datapath

sources:
  - files:
      - cpuPkg.sv
      - aluCtrlIf.sv
      - dataLatch.sv
      - aluCore.sv
      - decimalAdjust.sv
      - registerFile.sv
      - statusReg.sv
      - cpuDatapath.sv
  - target: test
    files:
      - tbCpuDatapath.sv
